/* busPkg.sv */
`default_nettype none

package busPkg;

	////////////////////////////////////////
	// Host bus fields
	////////////////////////////////////////

	typedef logic [9:0] regNumT;
	typedef logic [19:0] addrT;
	typedef logic [31:0] wordT;

	// One command per cmdValid strobe
	typedef struct packed {
		logic writeEnable;
		regNumT regNum;
		addrT address;
		wordT data;
	} hostCmdT;

	// Read data returned with respValid
	typedef struct packed {
		wordT data;
	} readRespT;

	////////////////////////////////////////
	// Register map
	////////////////////////////////////////

	// Weight bank k sits at regWeightBase + k
	localparam regNumT regWeightBase = 10'd1;

	// Read only
	localparam regNumT regReady = 10'd51;

	// Input vector, write starts and clears a run
	localparam regNumT regInput = 10'd100;

	// Read only hidden results
	localparam regNumT regHidden = 10'd1000;

endpackage

`default_nettype wire

/* compile.f */
nnPkg.sv
busPkg.sv
hostDecoder.sv
layerMemory.sv
macEngine.sv
hiddenLayer.sv
tbClock.sv
hiddenLayerTb.sv

/* hiddenLayer.sv */
`default_nettype none

module hiddenLayer #(
	parameter int numInputs = nnPkg::defaultInputs,
	parameter int numNeurons = nnPkg::defaultNeurons,
	localparam int bankW = (numNeurons > 1) ? $clog2(numNeurons) : 1
) (
	input wire CLOCK1_50,
	input wire resetHidden,
	input wire busPkg::hostCmdT cmd,
	input wire cmdValid,
	output busPkg::readRespT resp,
	output logic respValid
);

	// Decoder to memory
	logic inWe;
	busPkg::addrT inAddr;
	nnPkg::sampleT inData;
	logic wWe;
	logic [bankW-1:0] wBank;
	busPkg::addrT wAddr;
	nnPkg::sampleT wData;
	busPkg::addrT inReadIndex;
	nnPkg::sampleT inReadValue;

	// Decoder to engine
	logic start;
	logic clearReady;
	logic [bankW-1:0] hidIndex;
	nnPkg::accT hidValue;
	logic ready;

	// Engine to memory
	busPkg::addrT engineIndex;
	nnPkg::sampleT engineInput;
	nnPkg::sampleT [numNeurons-1:0] engineWeights;

	hostDecoder #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) decoder (
		.CLOCK1_50(CLOCK1_50),
		.resetHidden(resetHidden),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.inWe(inWe),
		.inAddr(inAddr),
		.inData(inData),
		.wWe(wWe),
		.wBank(wBank),
		.wAddr(wAddr),
		.wData(wData),
		.start(start),
		.clearReady(clearReady),
		.inReadIndex(inReadIndex),
		.inReadValue(inReadValue),
		.hidIndex(hidIndex),
		.hidValue(hidValue),
		.ready(ready),
		.resp(resp),
		.respValid(respValid)
	);

	layerMemory #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) memory (
		.CLOCK1_50(CLOCK1_50),
		.inWe(inWe),
		.inAddr(inAddr),
		.inData(inData),
		.wWe(wWe),
		.wBank(wBank),
		.wAddr(wAddr),
		.wData(wData),
		.readIndex(engineIndex),
		.inputOut(engineInput),
		.weightsOut(engineWeights),
		.hostIndex(inReadIndex),
		.hostValue(inReadValue)
	);

	macEngine #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) engine (
		.CLOCK1_50(CLOCK1_50),
		.resetHidden(resetHidden),
		.start(start),
		.clearReady(clearReady),
		.readIndex(engineIndex),
		.inputIn(engineInput),
		.weightsIn(engineWeights),
		.hidIndex(hidIndex),
		.hidValue(hidValue),
		.ready(ready)
	);

endmodule

`default_nettype wire

/* hiddenLayerTb.sv */
`default_nettype none

module hiddenLayerTb;

	localparam int numInputs = 16;
	localparam int numNeurons = 4;
	localparam int respTimeout = 10;
	localparam int resetTimeout = 10;
	localparam int pollLimit = 60;

	logic CLOCK1_50;
	logic resetHidden;
	busPkg::hostCmdT cmd;
	logic cmdValid;
	busPkg::readRespT resp;
	logic respValid;

	int mismatches = 0;
	int timeouts = 0;
	logic [31:0] lcgState = 32'h7a7f_b387;

	// Reference copies of what the DUT holds
	nnPkg::sampleT inputVec [numInputs];
	nnPkg::sampleT weightVec [numNeurons][numInputs];

	tbClock clockGen (
		.CLOCK1_50(CLOCK1_50),
		.resetHidden(resetHidden)
	);

	hiddenLayer #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) uut (
		.CLOCK1_50(CLOCK1_50),
		.resetHidden(resetHidden),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.resp(resp),
		.respValid(respValid)
	);

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Small signed values keep products well inside the accumulator
	function automatic nnPkg::sampleT nextSample();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return nnPkg::sampleT'($signed(lcgState[23:16]));
	endfunction

	// Copies the sample sign bit into every upper bit of the word
	function automatic busPkg::wordT extendSample(input nnPkg::sampleT s);
		return {{(32 - nnPkg::sampleWidth){s[nnPkg::sampleWidth-1]}}, s};
	endfunction

	// Wrapping 32-bit dot product of one neuron
	function automatic nnPkg::accT dotProduct(input int neuron);
		nnPkg::accT sum;
		sum = '0;
		for (int i = 0; i < numInputs; i++) begin
			sum = sum + nnPkg::accT'(inputVec[i]) * nnPkg::accT'(weightVec[neuron][i]);
		end
		return sum;
	endfunction

	task automatic checkWord(input string name, input busPkg::wordT got,
			input busPkg::wordT expected);
		assert (got == expected) else begin
			mismatches++;
			$display("mismatch at time %0t: %s got %0d expected %0d",
				$time, name, $signed(got), $signed(expected));
		end
	endtask

	task automatic writeReg(input busPkg::regNumT regNum, input busPkg::addrT address,
			input busPkg::wordT data);
		busPkg::hostCmdT c;
		c.writeEnable = 1'b1;
		c.regNum = regNum;
		c.address = address;
		c.data = data;
		@(posedge CLOCK1_50);
		cmd <= c;
		cmdValid <= 1'b1;
		@(posedge CLOCK1_50);
		cmdValid <= 1'b0;
	endtask

	task automatic readReg(input busPkg::regNumT regNum, input busPkg::addrT address,
			output busPkg::wordT data);
		busPkg::hostCmdT c;
		int waited;
		logic seen;
		c.writeEnable = 1'b0;
		c.regNum = regNum;
		c.address = address;
		c.data = '0;
		waited = 0;
		seen = 1'b0;
		data = '0;
		@(posedge CLOCK1_50);
		cmd <= c;
		cmdValid <= 1'b1;
		@(posedge CLOCK1_50);
		cmdValid <= 1'b0;
		// Sample away from the active edge
		while (!seen && waited < respTimeout) begin
			@(negedge CLOCK1_50);
			waited++;
			if (respValid) begin
				seen = 1'b1;
				data = resp.data;
			end
		end
		if (!seen) begin
			timeouts++;
			$display("timeout: no read response for register %0d address %0d",
				regNum, address);
		end
	endtask

	task automatic waitResetDone();
		int waited;
		waited = 0;
		while (resetHidden && waited < resetTimeout) begin
			@(negedge CLOCK1_50);
			waited++;
		end
		if (resetHidden) begin
			timeouts++;
			$display("timeout: reset never released");
		end
	endtask

	task automatic waitReady();
		busPkg::wordT got;
		int polls;
		logic isReady;
		polls = 0;
		isReady = 1'b0;
		while (!isReady && polls < pollLimit) begin
			readReg(busPkg::regReady, '0, got);
			isReady = (got == busPkg::wordT'(1));
			polls++;
		end
		if (!isReady) begin
			timeouts++;
			$display("timeout: ready flag did not rise after %0d polls", polls);
		end
	endtask

	// Fresh weights and inputs before every hidden value is compared
	task automatic loadAndRun();
		busPkg::wordT got;
		for (int k = 0; k < numNeurons; k++) begin
			for (int i = 0; i < numInputs; i++) begin
				weightVec[k][i] = nextSample();
				writeReg(busPkg::regWeightBase + busPkg::regNumT'(k), busPkg::addrT'(i),
					extendSample(weightVec[k][i]));
			end
		end
		// Last element starts the engine
		for (int i = 0; i < numInputs; i++) begin
			inputVec[i] = nextSample();
			writeReg(busPkg::regInput, busPkg::addrT'(i), extendSample(inputVec[i]));
		end
		waitReady();
		for (int k = 0; k < numNeurons; k++) begin
			readReg(busPkg::regHidden, busPkg::addrT'(k), got);
			checkWord($sformatf("hidden[%0d]", k), got, busPkg::wordT'(dotProduct(k)));
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		busPkg::wordT got;
		cmd = '0;
		cmdValid = 1'b0;
		waitResetDone();

		// Quiet bus after reset
		for (int n = 0; n < 4; n++) begin
			@(negedge CLOCK1_50);
			checkWord("respValid", busPkg::wordT'(respValid), '0);
		end
		readReg(busPkg::regReady, '0, got);
		checkWord("ready after reset", got, '0);

		// Input readback on a partial vector so no run starts
		for (int i = 0; i < 4; i++) begin
			inputVec[i] = nextSample();
			writeReg(busPkg::regInput, busPkg::addrT'(i), extendSample(inputVec[i]));
		end
		for (int i = 0; i < 4; i++) begin
			readReg(busPkg::regInput, busPkg::addrT'(i), got);
			checkWord($sformatf("input[%0d]", i), got, extendSample(inputVec[i]));
		end
		readReg(busPkg::regNumT'(500), '0, got);
		checkWord("unknown register", got, '0);

		loadAndRun();

		// Element 0 drops ready
		inputVec[0] = nextSample();
		writeReg(busPkg::regInput, '0, extendSample(inputVec[0]));
		readReg(busPkg::regReady, '0, got);
		checkWord("ready after clear", got, '0);

		loadAndRun();

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hostDecoder.sv */
`default_nettype none

module hostDecoder #(
	parameter int numInputs = nnPkg::defaultInputs,
	parameter int numNeurons = nnPkg::defaultNeurons,
	localparam int bankW = (numNeurons > 1) ? $clog2(numNeurons) : 1
) (
	input wire CLOCK1_50,
	input wire resetHidden,
	input wire busPkg::hostCmdT cmd,
	input wire cmdValid,

	output logic inWe,
	output busPkg::addrT inAddr,
	output nnPkg::sampleT inData,

	output logic wWe,
	output logic [bankW-1:0] wBank,
	output busPkg::addrT wAddr,
	output nnPkg::sampleT wData,

	output logic start,
	output logic clearReady,

	output busPkg::addrT inReadIndex,
	input wire nnPkg::sampleT inReadValue,

	output logic [bankW-1:0] hidIndex,
	input wire nnPkg::accT hidValue,
	input wire ready,

	output busPkg::readRespT resp,
	output logic respValid
);

	localparam busPkg::addrT lastAddr = busPkg::addrT'(numInputs - 1);

	logic writeStrobe;
	logic readStrobe;
	logic inRange;
	logic hidRange;
	logic weightHit;
	busPkg::regNumT bankSel;
	busPkg::wordT readMux;

	assign writeStrobe = cmdValid && cmd.writeEnable;
	assign readStrobe = cmdValid && !cmd.writeEnable;
	assign inRange = cmd.address < busPkg::addrT'(numInputs);
	assign hidRange = cmd.address < busPkg::addrT'(numNeurons);

	// Bank number relative to the first weight register
	assign bankSel = cmd.regNum - busPkg::regWeightBase;
	assign weightHit = (cmd.regNum >= busPkg::regWeightBase) &&
		(bankSel < busPkg::regNumT'(numNeurons));

	////////////////////////////////////////
	// Write routing
	////////////////////////////////////////

	assign inWe = writeStrobe && (cmd.regNum == busPkg::regInput) && inRange;
	assign inAddr = cmd.address;
	assign inData = nnPkg::sampleT'(cmd.data[nnPkg::sampleWidth-1:0]);

	assign wWe = writeStrobe && weightHit && inRange;
	assign wBank = bankSel[bankW-1:0];
	assign wAddr = cmd.address;
	assign wData = nnPkg::sampleT'(cmd.data[nnPkg::sampleWidth-1:0]);

	// Element 0 marks the start of a new input vector
	assign clearReady = inWe && (cmd.address == '0);

	////////////////////////////////////////
	// Read path
	////////////////////////////////////////

	assign inReadIndex = cmd.address;
	assign hidIndex = cmd.address[bankW-1:0];

	always_comb begin
		readMux = '0;
		case (cmd.regNum)
			busPkg::regInput: begin
				// Sign extend through the accumulator type
				if (inRange) begin
					readMux = busPkg::wordT'(nnPkg::accT'(inReadValue));
				end
			end
			busPkg::regReady: begin
				readMux = busPkg::wordT'(ready);
			end
			busPkg::regHidden: begin
				if (hidRange) begin
					readMux = busPkg::wordT'(hidValue);
				end
			end
			default: begin
				readMux = '0;
			end
		endcase
	end

	// Strobes, one cycle after the command
	always_ff @(posedge CLOCK1_50) begin
		if (resetHidden) begin
			start <= 1'b0;
			respValid <= 1'b0;
		end else begin
			start <= inWe && (cmd.address == lastAddr);
			respValid <= readStrobe;
		end
	end

	always_ff @(posedge CLOCK1_50) begin
		if (readStrobe) begin
			resp.data <= readMux;
		end
	end

endmodule

`default_nettype wire

/* layerMemory.sv */
`default_nettype none

module layerMemory #(
	parameter int numInputs = nnPkg::defaultInputs,
	parameter int numNeurons = nnPkg::defaultNeurons,
	localparam int bankW = (numNeurons > 1) ? $clog2(numNeurons) : 1,
	localparam int idxW = (numInputs > 1) ? $clog2(numInputs) : 1
) (
	input wire CLOCK1_50,

	// Host write ports
	input wire inWe,
	input wire busPkg::addrT inAddr,
	input wire nnPkg::sampleT inData,
	input wire wWe,
	input wire [bankW-1:0] wBank,
	input wire busPkg::addrT wAddr,
	input wire nnPkg::sampleT wData,

	// Engine read port, one cycle latency
	input wire busPkg::addrT readIndex,
	output nnPkg::sampleT inputOut,
	output nnPkg::sampleT [numNeurons-1:0] weightsOut,

	// Host readback of the input vector
	input wire busPkg::addrT hostIndex,
	output nnPkg::sampleT hostValue
);

	nnPkg::sampleT inputMem [numInputs];

	// One bank per neuron, all read at the same index
	nnPkg::sampleT weightMem [numNeurons][numInputs];

	logic [idxW-1:0] engineIdx;

	assign engineIdx = readIndex[idxW-1:0];

	////////////////////////////////////////
	// Input vector
	////////////////////////////////////////

	always_ff @(posedge CLOCK1_50) begin
		if (inWe) begin
			inputMem[inAddr[idxW-1:0]] <= inData;
		end
		inputOut <= inputMem[engineIdx];
	end

	assign hostValue = inputMem[hostIndex[idxW-1:0]];

	////////////////////////////////////////
	// Weight banks
	////////////////////////////////////////

	always_ff @(posedge CLOCK1_50) begin
		if (wWe) begin
			weightMem[wBank][wAddr[idxW-1:0]] <= wData;
		end
		// Every neuron gets its weight for the current input
		for (int k = 0; k < numNeurons; k++) begin
			weightsOut[k] <= weightMem[k][engineIdx];
		end
	end

endmodule

`default_nettype wire

/* macEngine.sv */
`default_nettype none

module macEngine #(
	parameter int numInputs = nnPkg::defaultInputs,
	parameter int numNeurons = nnPkg::defaultNeurons,
	localparam int bankW = (numNeurons > 1) ? $clog2(numNeurons) : 1
) (
	input wire CLOCK1_50,
	input wire resetHidden,
	input wire start,
	input wire clearReady,

	// Memory read at readIndex returns data next cycle
	output busPkg::addrT readIndex,
	input wire nnPkg::sampleT inputIn,
	input wire nnPkg::sampleT [numNeurons-1:0] weightsIn,

	// Hidden result readback
	input wire [bankW-1:0] hidIndex,
	output nnPkg::accT hidValue,
	output logic ready
);

	localparam busPkg::addrT lastIndex = busPkg::addrT'(numInputs - 1);

	nnPkg::engineStateT state;
	busPkg::addrT index;
	logic issue;

	// Valid and last flags follow each input down the pipe
	logic rdValid;
	logic rdLast;
	logic mulValid;
	logic mulLast;

	nnPkg::productT product [numNeurons];
	nnPkg::accT acc [numNeurons];
	nnPkg::accT hidden [numNeurons];

	assign issue = (state == nnPkg::run);
	assign readIndex = index;
	assign hidValue = hidden[hidIndex];

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////

	always_ff @(posedge CLOCK1_50) begin
		if (resetHidden) begin
			state <= nnPkg::idle;
			index <= '0;
			rdValid <= 1'b0;
			rdLast <= 1'b0;
			mulValid <= 1'b0;
			mulLast <= 1'b0;
			ready <= 1'b0;
		end else begin
			rdValid <= issue;
			rdLast <= issue && (index == lastIndex);
			mulValid <= rdValid;
			mulLast <= rdLast;

			case (state)
				nnPkg::idle: begin
					if (start) begin
						state <= nnPkg::run;
						index <= '0;
					end
				end
				nnPkg::run: begin
					// Hold the index on the last element
					if (index == lastIndex) begin
						state <= nnPkg::drain;
					end else begin
						index <= index + 1'b1;
					end
				end
				nnPkg::drain: begin
					if (mulLast) begin
						state <= nnPkg::done;
					end
				end
				nnPkg::done: begin
					if (start) begin
						state <= nnPkg::run;
						index <= '0;
					end else if (clearReady) begin
						state <= nnPkg::idle;
					end
				end
				default: begin
					state <= nnPkg::idle;
				end
			endcase

			if (start || clearReady) begin
				ready <= 1'b0;
			end else if (mulLast) begin
				ready <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Multiply and accumulate lanes
	////////////////////////////////////////

	always_ff @(posedge CLOCK1_50) begin
		for (int k = 0; k < numNeurons; k++) begin
			// Stage 2, one multiplier per neuron
			if (rdValid) begin
				product[k] <= inputIn * $signed(weightsIn[k]);
			end

			// Stage 3
			if (start || clearReady) begin
				acc[k] <= '0;
			end else if (mulValid) begin
				acc[k] <= acc[k] + product[k];
			end

			// Final sum goes straight to the result file
			if (mulLast) begin
				hidden[k] <= acc[k] + product[k];
			end
		end
	end

endmodule

`default_nettype wire

/* nnPkg.sv */
`default_nettype none

package nnPkg;

	////////////////////////////////////////
	// Layer dimensions
	////////////////////////////////////////

	// Full-size network, overridden from the top level
	localparam int defaultInputs = 784;
	localparam int defaultNeurons = 40;

	////////////////////////////////////////
	// Numeric types
	////////////////////////////////////////

	localparam int sampleWidth = 16;
	localparam int accWidth = 32;

	// Input element or weight
	typedef logic signed [sampleWidth-1:0] sampleT;

	// Running sum and hidden result, wraps on overflow
	typedef logic signed [accWidth-1:0] accT;

	// Full-precision product of two samples
	typedef logic signed [2*sampleWidth-1:0] productT;

	// MAC engine control
	typedef enum logic [1:0] {
		idle,
		run,
		drain,
		done
	} engineStateT;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the hidden layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildLog=build.log
simLog=sim.log

verilator --binary --timing --assert \
	--top-module hiddenLayerTb \
	-f compile.f \
	-Mdir obj_dir \
	-o simHidden > "$buildLog" 2>&1
if [ $? -ne 0 ]; then
	cat "$buildLog"
	echo "build failed"
	exit 1
fi

./obj_dir/simHidden > "$simLog" 2>&1
if [ $? -ne 0 ]; then
	cat "$simLog"
	echo "simulation exited with an error"
	exit 1
fi

cat "$simLog"
if grep -q '\*\* FAIL \*\*' "$simLog"; then
	exit 1
fi
exit 0

/* tbClock.sv */
`default_nettype none

module tbClock (
	output logic CLOCK1_50,
	output logic resetHidden
);

	localparam int halfPeriod = 50;
	localparam int resetCycles = 2;

	initial begin
		CLOCK1_50 = 1'b0;
		forever begin
			#halfPeriod CLOCK1_50 = ~CLOCK1_50;
		end
	end

	// Synchronous reset held for the first edges
	initial begin
		resetHidden = 1'b1;
		repeat (resetCycles) @(posedge CLOCK1_50);
		resetHidden <= 1'b0;
	end

endmodule

`default_nettype wire
